// ==== Bender.yml ====
package:
  name: matrix_ctrl

sources:
  - source/matrix_ctrl_pkg.sv
  - source/cmd_decoder.sv
  - source/pixel_writer.sv
  - source/panel_blanker.sv
  - source/matrix_ctrl.sv
  - target: test
    files:
      - dv/matrix_ctrl_props.sv
      - dv/matrix_ctrl_tb.sv

// ==== dv/matrix_ctrl_props.sv ====
//##########################################################################
// concurrent checks on the byte handshake and the frame RAM write port
// bound into every matrix_ctrl instance
//##########################################################################
`timescale 1ns/10ps

module matrix_ctrl_props
    import matrix_ctrl_pkg::*;
(
    input logic                     clk_in,
    input logic                     reset,
    input logic                     byte_valid,
    input logic                     byte_ready,
    input logic                     pixel_byte_strobe,
    input logic                     blank_start,
    input logic                     blank_active,
    input logic                     blank_done,
    input logic                     ram_we,
    input logic [RAM_ADDR_BITS-1:0] wr_addr,
    input logic [7:0]               wr_data
);

    int violations = 0;

    ready_after_reset: assert property (@(posedge clk_in) reset |=> byte_ready)
        else begin
            violations++;
            $error("byte_ready is low right after reset");
        end

    // an opcode or brightness argument never produces a RAM write
    no_write_on_opcode: assert property (@(posedge clk_in) disable iff (reset)
        (byte_valid && byte_ready && !pixel_byte_strobe && !blank_start) |=> !ram_we)
        else begin
            violations++;
            $error("RAM write after a single-byte command");
        end

    blank_first_addr: assert property (@(posedge clk_in) disable iff (reset)
        blank_start |=> (blank_active && wr_addr == '0))
        else begin
            violations++;
            $error("blank pass does not start at address zero");
        end

    blank_zero_data: assert property (@(posedge clk_in) disable iff (reset)
        blank_active |-> (ram_we && wr_data == 8'h00))
        else begin
            violations++;
            $error("blank pass write missing or data not zero");
        end

    blank_addr_step: assert property (@(posedge clk_in) disable iff (reset)
        (blank_active && !blank_done) |=> (wr_addr == $past(wr_addr) + 1'b1))
        else begin
            violations++;
            $error("blank pass address did not step by one");
        end

endmodule

bind matrix_ctrl matrix_ctrl_props i_props (
    .clk_in           (clk_in),
    .reset            (reset),
    .byte_valid       (byte_valid),
    .byte_ready       (byte_ready),
    .pixel_byte_strobe(pixel_byte_strobe),
    .blank_start      (blank_start),
    .blank_active     (blank_active),
    .blank_done       (blank_done),
    .ram_we           (ram_we),
    .wr_addr          (ram_wr.addr),
    .wr_data          (ram_wr.data)
);

// ==== dv/matrix_ctrl_tb.sv ====
//##########################################################################
// self-checking testbench for the LED matrix command front end
// sends a table of command sequences through the byte handshake
//##########################################################################
`timescale 1ns/10ps

module matrix_ctrl_tb
    import matrix_ctrl_pkg::*;
();

    typedef enum logic [1:0] {WR_NONE, WR_PIXEL, WR_BLANK} wr_kind_e;

    // rand_mask bit i marks cmd[i] for a random byte
    typedef struct packed {
        logic [3:0]                   n_bytes;
        logic [0:4][7:0]              cmd;
        logic [4:0]                   rand_mask;
        logic [2:0]                   exp_rgb;
        logic [BRIGHTNESS_LEVELS-1:0] exp_bright;
        logic [2:0]                   bright_arg;
        wr_kind_e                     kind;
        logic [8:0]                   n_writes;
        logic [RAM_ADDR_BITS-1:0]     first_addr;
        logic [7:0]                   first_data;
    } test_row_t;

    logic                         clk_in;
    logic                         reset;
    logic [7:0]                   byte_in;
    logic                         byte_valid;
    logic                         byte_ready;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    ram_write_t                   ram_wr;
    logic                         ram_we;

    test_row_t  table_q[$];
    string      name_q[$];
    ram_write_t writes_q[$];
    int         ready_low;
    int         row_errors;
    int         pass_count;
    int         fail_count;
    int         limit_cycles = 0;

    matrix_ctrl i_matrix_ctrl (
        .clk_in           (clk_in),
        .reset            (reset),
        .byte_in          (byte_in),
        .byte_valid       (byte_valid),
        .byte_ready       (byte_ready),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_wr           (ram_wr),
        .ram_we           (ram_we)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // RAM port and ready are sampled mid-cycle
    always @(negedge clk_in) begin
        if (!reset) begin
            if (ram_we) writes_q.push_back(ram_wr);
            if (!byte_ready) ready_low++;
        end
    end

    function automatic logic [BRIGHTNESS_LEVELS-1:0] bright_bit(input int k);
        return 1 << (BRIGHTNESS_LEVELS - k);
    endfunction

    task automatic add_row(input string name, input int n, input logic [0:4][7:0] cmd,
                           input logic [4:0] mask, input logic [2:0] rgb,
                           input logic [BRIGHTNESS_LEVELS-1:0] bright,
                           input logic [2:0] arg, input wr_kind_e kind);
        test_row_t r;
        r.n_bytes = n;
        r.cmd = cmd;
        r.rand_mask = mask;
        r.exp_rgb = rgb;
        r.exp_bright = bright;
        r.bright_arg = arg;
        r.kind = kind;
        r.n_writes = (kind == WR_BLANK) ? RAM_DEPTH : 0;
        r.first_addr = '0;
        r.first_data = 8'h00;
        table_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic load_table();
        add_row("reset_values", 0, '0, 5'b0, 3'b111, '1, 3'd0, WR_NONE);
        add_row("colour_cmds", 3, {RED_OFF, BLUE_OFF, RED_ON, 8'h00, 8'h00},
                5'b0, 3'b011, '1, 3'd0, WR_NONE);
        add_row("unknown_opcode", 2, {8'h00, 8'hff, 8'h00, 8'h00, 8'h00},
                5'b0, 3'b011, '1, 3'd0, WR_NONE);
        add_row("bright_bits", 3, {BRIGHT_NONE, BRIGHT_BIT_1, BRIGHT_BIT_3, 8'h00, 8'h00},
                5'b0, 3'b011, bright_bit(1) | bright_bit(3), 3'd0, WR_NONE);
        add_row("bright_toggle", 1, {BRIGHT_BIT_1, 8'h00, 8'h00, 8'h00, 8'h00},
                5'b0, 3'b011, bright_bit(3), 3'd0, WR_NONE);
        add_row("bright_all", 1, {BRIGHT_ALL, 8'h00, 8'h00, 8'h00, 8'h00},
                5'b0, 3'b011, '1, 3'd0, WR_NONE);
        add_row("write_pixel", 5, {WRITE_PIXEL, 8'h00, 8'h00, 8'h00, 8'h00},
                5'b11110, 3'b011, '1, 3'd0, WR_PIXEL);
        add_row("blank_panel", 2, {BLANK_PANEL, GREEN_OFF, 8'h00, 8'h00, 8'h00},
                5'b0, 3'b001, '1, 3'd0, WR_BLANK);
        add_row("set_brightness", 3, {SET_BRIGHTNESS, 8'h00, BLUE_ON, 8'h00, 8'h00},
                5'b00010, 3'b101, '0, 3'd1, WR_NONE);
    endtask

    function automatic test_row_t patch_row(input test_row_t r);
        for (int i = 0; i < 5; i++) begin
            if (r.rand_mask[i]) r.cmd[i] = 8'($urandom);
        end
        if (r.bright_arg != 0) r.exp_bright = r.cmd[r.bright_arg][BRIGHTNESS_LEVELS-1:0];
        if (r.kind == WR_PIXEL) begin
            // row and column truncate, data byte 0 lands in the top select slot
            r.n_writes = BYTES_PER_PIXEL;
            r.first_addr = {r.cmd[1][ROW_BITS-1:0], r.cmd[2][COL_BITS-1:0],
                            SEL_BITS'(BYTES_PER_PIXEL - 1)};
            r.first_data = r.cmd[3];
        end
        return r;
    endfunction

    task automatic check(input string test, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int   gap;
        logic rdy;
        gap = $urandom_range(2, 0);
        if (gap != 0) begin
            byte_valid <= 1'b0;
            repeat (gap) @(posedge clk_in);
        end
        byte_in <= b;
        byte_valid <= 1'b1;
        do begin
            @(negedge clk_in);
            rdy = byte_ready;
            @(posedge clk_in);
        end while (!rdy);
    endtask

    task automatic check_writes(input string name, input test_row_t r);
        logic [RAM_ADDR_BITS-1:0] exp_addr;
        logic [7:0]               exp_data;
        check(name, "write count", r.n_writes, writes_q.size());
        check(name, "ready low cycles", (r.kind == WR_BLANK) ? RAM_DEPTH : 0, ready_low);
        foreach (writes_q[i]) begin
            if (r.kind == WR_PIXEL) begin
                exp_addr = r.first_addr - i;
                exp_data = r.cmd[3 + i];
            end else begin
                exp_addr = r.first_addr + i;
                exp_data = r.first_data;
            end
            check(name, $sformatf("write %0d addr", i), exp_addr, writes_q[i].addr);
            check(name, $sformatf("write %0d data", i), exp_data, writes_q[i].data);
        end
    endtask

    initial begin
        int        total_bytes;
        int        assert_errors;
        test_row_t row;
        void'($urandom(32'h500f));
        reset = 1'b1;
        byte_in = 8'h00;
        byte_valid = 1'b0;
        pass_count = 0;
        fail_count = 0;
        load_table();
        total_bytes = 0;
        foreach (table_q[t]) total_bytes += table_q[t].n_bytes;
        limit_cycles = (total_bytes + RAM_DEPTH) * 8 + 32;
        repeat (4) @(posedge clk_in);
        reset <= 1'b0;
        foreach (table_q[t]) begin
            row = patch_row(table_q[t]);
            row_errors = 0;
            writes_q.delete();
            ready_low = 0;
            for (int i = 0; i < row.n_bytes; i++) send_byte(row.cmd[i]);
            byte_valid <= 1'b0;
            // the last data byte is written in the cycle after it transfers
            @(posedge clk_in);
            @(negedge clk_in);
            check(name_q[t], "rgb_enable", row.exp_rgb, rgb_enable);
            check(name_q[t], "brightness_enable", row.exp_bright, brightness_enable);
            check_writes(name_q[t], row);
            if (row_errors == 0) begin
                pass_count++;
                $display("test %s: ok", name_q[t]);
            end else begin
                fail_count++;
                $display("test %s: %0d mismatches", name_q[t], row_errors);
            end
            @(posedge clk_in);
        end
        assert_errors = i_matrix_ctrl.i_props.violations;
        if (assert_errors != 0) $display("%0d assertion violations seen", assert_errors);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk_in);
        $display("run timed out after %0d clock cycles", limit_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== matrix_ctrl.f ====
source/matrix_ctrl_pkg.sv
source/cmd_decoder.sv
source/pixel_writer.sv
source/panel_blanker.sv
source/matrix_ctrl.sv
dv/matrix_ctrl_props.sv
dv/matrix_ctrl_tb.sv

// ==== source/cmd_decoder.sv ====
//##########################################################################
// command byte decoder with the ready/valid byte handshake
// holds the colour and brightness enables, hands argument bytes to writers
//##########################################################################
`timescale 1ns/10ps

module cmd_decoder
    import matrix_ctrl_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   byte_in,
    input  logic                         byte_valid,
    output logic                         byte_ready,
    input  logic                         blank_done,
    input  logic                         pixel_done,
    output logic                         pixel_byte_strobe,
    output logic [7:0]                   pixel_byte,
    output logic                         blank_start,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    ctrl_state_e                  state;
    ctrl_state_e                  state_next;
    opcode_e                      opcode;
    logic                         xfer;
    logic                         cmd_phase;
    logic [2:0]                   rgb_next;
    logic [BRIGHTNESS_LEVELS-1:0] bright_next;
    logic [2:0]                   toggle_k;

    assign opcode = opcode_e'(byte_in);
    assign byte_ready = (state != BLANK);
    assign xfer = byte_valid && byte_ready;

    // the cycle of the last pixel write already accepts the next opcode
    assign cmd_phase = (state == IDLE) || (state == PIXEL && pixel_done);

    assign pixel_byte_strobe = xfer && (state == PIXEL) && !pixel_done;
    assign pixel_byte = byte_in;
    assign blank_start = xfer && cmd_phase && (opcode == BLANK_PANEL);

    always_comb begin
        state_next = state;
        rgb_next = rgb_enable;
        bright_next = brightness_enable;
        toggle_k = 3'd0;

        case (state)
            GET_BRIGHTNESS: begin
                if (xfer) begin
                    bright_next = byte_in[BRIGHTNESS_LEVELS-1:0];
                    state_next = IDLE;
                end
            end
            PIXEL: if (pixel_done) state_next = IDLE;
            BLANK: if (blank_done) state_next = IDLE;
            default: ;
        endcase

        if (xfer && cmd_phase) begin
            case (opcode)
                RED_ON:         rgb_next[0] = 1'b1;
                RED_OFF:        rgb_next[0] = 1'b0;
                GREEN_ON:       rgb_next[1] = 1'b1;
                GREEN_OFF:      rgb_next[1] = 1'b0;
                BLUE_ON:        rgb_next[2] = 1'b1;
                BLUE_OFF:       rgb_next[2] = 1'b0;
                BRIGHT_BIT_1:   toggle_k = 3'd1;
                BRIGHT_BIT_2:   toggle_k = 3'd2;
                BRIGHT_BIT_3:   toggle_k = 3'd3;
                BRIGHT_BIT_4:   toggle_k = 3'd4;
                BRIGHT_BIT_5:   toggle_k = 3'd5;
                BRIGHT_BIT_6:   toggle_k = 3'd6;
                BRIGHT_NONE:    bright_next = '0;
                BRIGHT_ALL:     bright_next = '1;
                SET_BRIGHTNESS: state_next = GET_BRIGHTNESS;
                BLANK_PANEL:    state_next = BLANK;
                WRITE_PIXEL:    state_next = PIXEL;
                // unknown bytes are dropped
                default: ;
            endcase
        end

        // bit k counts down from the msb
        if (toggle_k != 3'd0) begin
            bright_next[BRIGHTNESS_LEVELS - toggle_k] =
                ~brightness_enable[BRIGHTNESS_LEVELS - toggle_k];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            state <= state_next;
            rgb_enable <= rgb_next;
            brightness_enable <= bright_next;
        end
    end

endmodule

// ==== source/matrix_ctrl.sv ====
//##########################################################################
// LED matrix command front end: byte stream in, frame RAM writes out
// the blanker owns the RAM port while its sweep runs
//##########################################################################
`timescale 1ns/10ps

module matrix_ctrl
    import matrix_ctrl_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   byte_in,
    input  logic                         byte_valid,
    output logic                         byte_ready,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output ram_write_t                   ram_wr,
    output logic                         ram_we
);

    logic       pixel_byte_strobe;
    logic [7:0] pixel_byte;
    logic       pixel_done;
    logic       blank_start;
    logic       blank_done;
    logic       blank_active;
    ram_write_t pixel_wr;
    ram_write_t blank_wr;
    logic       pixel_we;
    logic       blank_we;

    cmd_decoder i_cmd_decoder (
        .clk_in           (clk_in),
        .reset            (reset),
        .byte_in          (byte_in),
        .byte_valid       (byte_valid),
        .byte_ready       (byte_ready),
        .blank_done       (blank_done),
        .pixel_done       (pixel_done),
        .pixel_byte_strobe(pixel_byte_strobe),
        .pixel_byte       (pixel_byte),
        .blank_start      (blank_start),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    pixel_writer i_pixel_writer (
        .clk_in           (clk_in),
        .reset            (reset),
        .pixel_byte_strobe(pixel_byte_strobe),
        .pixel_byte       (pixel_byte),
        .pixel_wr         (pixel_wr),
        .pixel_we         (pixel_we),
        .pixel_done       (pixel_done)
    );

    panel_blanker i_panel_blanker (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .blank_wr    (blank_wr),
        .blank_we    (blank_we),
        .blank_active(blank_active),
        .blank_done  (blank_done)
    );

    // RAM write source select
    always_comb begin
        if (blank_active) begin
            ram_wr = blank_wr;
            ram_we = blank_we;
        end else begin
            ram_wr = pixel_wr;
            ram_we = pixel_we;
        end
    end

endmodule

// ==== source/matrix_ctrl_pkg.sv ====
//##########################################################################
// shared geometry, opcode and state encodings for the LED matrix front end
// imported by every RTL block and by the testbench
//##########################################################################
package matrix_ctrl_pkg;

    // panel geometry
    localparam int unsigned PIXEL_WIDTH = 16;
    localparam int unsigned PIXEL_HEIGHT = 8;
    localparam int unsigned BYTES_PER_PIXEL = 2;
    localparam int unsigned BRIGHTNESS_LEVELS = 6;

    localparam int unsigned ROW_BITS = $clog2(PIXEL_HEIGHT);
    localparam int unsigned COL_BITS = $clog2(PIXEL_WIDTH);
    localparam int unsigned SEL_BITS = $clog2(BYTES_PER_PIXEL);
    localparam int unsigned RAM_ADDR_BITS = ROW_BITS + COL_BITS + SEL_BITS;
    localparam int unsigned RAM_DEPTH = 1 << RAM_ADDR_BITS;

    // row and column bytes come ahead of the pixel data
    localparam int unsigned PIXEL_ARG_BYTES = 2 + BYTES_PER_PIXEL;
    localparam int unsigned PIXEL_CNT_BITS = $clog2(PIXEL_ARG_BYTES);

    // command bytes, printable ascii
    typedef enum logic [7:0] {
        RED_ON         = 8'h52,
        RED_OFF        = 8'h72,
        GREEN_ON       = 8'h47,
        GREEN_OFF      = 8'h67,
        BLUE_ON        = 8'h42,
        BLUE_OFF       = 8'h62,
        BRIGHT_BIT_1   = 8'h31,
        BRIGHT_BIT_2   = 8'h32,
        BRIGHT_BIT_3   = 8'h33,
        BRIGHT_BIT_4   = 8'h34,
        BRIGHT_BIT_5   = 8'h35,
        BRIGHT_BIT_6   = 8'h36,
        BRIGHT_NONE    = 8'h30,
        BRIGHT_ALL     = 8'h39,
        SET_BRIGHTNESS = 8'h54,
        BLANK_PANEL    = 8'h5a,
        WRITE_PIXEL    = 8'h50
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        GET_BRIGHTNESS,
        PIXEL,
        BLANK
    } ctrl_state_e;

    // packed in this order it is the frame RAM address
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic [SEL_BITS-1:0] sel;
    } pixel_addr_t;

    typedef struct packed {
        pixel_addr_t addr;
        logic [7:0]  data;
    } ram_write_t;

endpackage

// ==== source/panel_blanker.sv ====
//##########################################################################
// BLANK_PANEL sweep, one zero write per cycle over the whole frame RAM
//##########################################################################
`timescale 1ns/10ps

module panel_blanker
    import matrix_ctrl_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic       blank_start,
    output ram_write_t blank_wr,
    output logic       blank_we,
    output logic       blank_active,
    output logic       blank_done
);

    logic [RAM_ADDR_BITS-1:0] addr_q;

    assign blank_wr.addr = pixel_addr_t'(addr_q);
    assign blank_wr.data = 8'h00;
    assign blank_we = blank_active;
    assign blank_done = blank_active && (addr_q == RAM_ADDR_BITS'(RAM_DEPTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            addr_q <= '0;
            blank_active <= 1'b0;
        end else if (blank_start) begin
            addr_q <= '0;
            blank_active <= 1'b1;
        end else if (blank_active) begin
            addr_q <= addr_q + 1'b1;
            if (blank_done) blank_active <= 1'b0;
        end
    end

endmodule

// ==== source/pixel_writer.sv ====
//##########################################################################
// WRITE_PIXEL argument collector: row, column, then the pixel data bytes
// each data byte becomes one frame RAM write the cycle after it arrives
//##########################################################################
`timescale 1ns/10ps

module pixel_writer
    import matrix_ctrl_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic       pixel_byte_strobe,
    input  logic [7:0] pixel_byte,
    output ram_write_t pixel_wr,
    output logic       pixel_we,
    output logic       pixel_done
);

    logic [PIXEL_CNT_BITS-1:0] byte_cnt;
    logic [PIXEL_CNT_BITS-1:0] data_idx;
    logic [ROW_BITS-1:0]       row_q;
    logic [COL_BITS-1:0]       col_q;
    logic                      last_byte;

    assign data_idx = byte_cnt - PIXEL_CNT_BITS'(2);
    assign last_byte = (byte_cnt == PIXEL_CNT_BITS'(PIXEL_ARG_BYTES - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            byte_cnt <= '0;
            pixel_we <= 1'b0;
            pixel_done <= 1'b0;
        end else begin
            pixel_we <= 1'b0;
            pixel_done <= 1'b0;
            if (pixel_byte_strobe) begin
                if (last_byte) begin
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
                pixel_we <= (byte_cnt >= PIXEL_CNT_BITS'(2));
                pixel_done <= last_byte;
            end
        end
    end

    // address fields and write payload
    always_ff @(posedge clk_in) begin
        if (pixel_byte_strobe) begin
            if (byte_cnt == '0) begin
                row_q <= pixel_byte[ROW_BITS-1:0];
            end else if (byte_cnt == PIXEL_CNT_BITS'(1)) begin
                col_q <= pixel_byte[COL_BITS-1:0];
            end else begin
                pixel_wr.addr.row <= row_q;
                pixel_wr.addr.col <= col_q;
                // inverted select keeps byte 0 in the upper slot
                pixel_wr.addr.sel <= ~data_idx[SEL_BITS-1:0];
                pixel_wr.data <= pixel_byte;
            end
        end
    end

endmodule
